/* cache_testdata.txt */
# op (0 read, 1 write, 2 reset) address mask pattern expect_hit expect_writeback
# tags A=0001 B=0002 C=0003 D=0004 all map to set 1
0 00010024 00000000 00000000 0 0
1 00010020 000000f0 deadbeef 1 0
0 00010020 00000000 00000000 1 0
0 00020020 00000000 00000000 0 0
0 00010020 00000000 00000000 1 0
0 00030020 00000000 00000000 0 0
0 00010020 00000000 00000000 1 0
0 00020020 00000000 00000000 0 0
0 00040020 00000000 00000000 0 1
0 00010020 00000000 00000000 0 0
1 00050040 ffffffff 12345678 0 0
0 00050040 00000000 00000000 1 0
0 00060040 00000000 00000000 0 0
0 00070040 00000000 00000000 0 1
2 00000000 00000000 00000000 0 0
0 00050040 00000000 00000000 0 0
0 00010024 00000000 00000000 0 0
1 000800a0 0f0f0f0f cafef00d 0 0
0 000800a0 00000000 00000000 1 0
0 00020020 00000000 00000000 0 0

/* tb.f */
cache_pkg.sv
cache_way_if.sv
cache_way.sv
cache_way_select.sv
cache_control.sv
cache_top.sv
cache_checker.sv
tb_cache.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_cache
FILELIST  := tb.f
FLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx '=== PASS ===' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_cache.sv */
/* Testbench for the two-way cache: clock, reset, operations read
   from the data file, and a line memory with random latency */
`timescale 1ns/100ps
`default_nettype none

module tb_cache import cache_pkg::*; ();

    logic clk;
    logic rst_n_i;
    logic mem_read_i;
    logic mem_write_i;
    logic [31:0] mem_addr_i;
    logic [MASK_BITS-1:0] mem_byte_enable_i;
    logic [LINE_BITS-1:0] mem_wdata_i;
    logic [LINE_BITS-1:0] mem_rdata_o;
    logic mem_resp_o;
    logic pmem_read_o;
    logic pmem_write_o;
    logic [31:0] pmem_address_o;
    logic [LINE_BITS-1:0] pmem_wdata_o;
    logic [LINE_BITS-1:0] pmem_rdata_i;
    logic pmem_resp_i;
    logic expect_hit;
    logic expect_wb;
    int error_count;
    int check_count;

    int op_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] mask_q[$];
    logic [31:0] pattern_q[$];
    int hit_q[$];
    int wb_q[$];
    int cycle_limit;
    int cycle_count;
    logic [31:0] lfsr_q;
    logic mem_busy;
    int mem_wait;
    logic [LINE_BITS-1:0] mem_store [logic [31:0]];

    cache_top #(.S_INDEX(3)) cache_top_i (
        .clk, .rst_n_i, .mem_read_i, .mem_write_i, .mem_addr_i, .mem_byte_enable_i,
        .mem_wdata_i, .mem_rdata_o, .mem_resp_o, .pmem_read_o, .pmem_write_o,
        .pmem_address_o, .pmem_wdata_o, .pmem_rdata_i, .pmem_resp_i
    );

    cache_checker cache_checker_i (
        .clk, .rst_n_i, .mem_read_i, .mem_write_i, .mem_addr_i, .mem_byte_enable_i,
        .mem_wdata_i, .rdata_i(mem_rdata_o), .resp_i(mem_resp_o),
        .pmem_read_i(pmem_read_o), .pmem_write_i(pmem_write_o),
        .pmem_address_i(pmem_address_o), .pmem_wdata_i(pmem_wdata_o),
        .expect_hit_i(expect_hit), .expect_wb_i(expect_wb),
        .error_count_o(error_count), .check_count_o(check_count)
    );

    // untouched memory lines hold a value built from the line address and word position
    function automatic logic [LINE_BITS-1:0] fill_line(input logic [31:0] addr);
        logic [LINE_BITS-1:0] line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = {addr[31:5], 3'(w), 2'b00} ^ 32'h3c96_a55a;
        end
        return line;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic apply_reset();
        rst_n_i <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
    endtask

    task automatic load_operations();
        int fd;
        int n;
        int op;
        int hit;
        int wb;
        logic [31:0] addr;
        logic [31:0] mask;
        logic [31:0] pattern;
        string text;
        fd = $fopen("cache_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open cache_testdata.txt, no stimulus to run");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                if (n > 0 && text[0] != "#") begin
                    n = $sscanf(text, "%d %h %h %h %d %d", op, addr, mask, pattern, hit, wb);
                    if (n == 6) begin
                        op_q.push_back(op);
                        addr_q.push_back(addr);
                        mask_q.push_back(mask);
                        pattern_q.push_back(pattern);
                        hit_q.push_back(hit);
                        wb_q.push_back(wb);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // each request is held until the cache answers it
    task automatic run_operations();
        for (int i = 0; i < op_q.size(); i++) begin
            if (op_q[i] == 2) begin
                mem_read_i <= 1'b0;
                mem_write_i <= 1'b0;
                apply_reset();
                @(posedge clk);
            end else begin
                mem_read_i <= (op_q[i] == 0);
                mem_write_i <= (op_q[i] == 1);
                mem_addr_i <= addr_q[i];
                mem_byte_enable_i <= mask_q[i];
                mem_wdata_i <= {8{pattern_q[i]}};
                expect_hit <= (hit_q[i] != 0);
                expect_wb <= (wb_q[i] != 0);
                do @(negedge clk); while (!mem_resp_o);
                @(posedge clk);
            end
        end
    endtask

    // memory model answers 1 to 8 cycles after a strobe starts
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pmem_resp_i <= 1'b0;
            mem_busy = 1'b0;
            mem_wait = 0;
        end else begin
            pmem_resp_i <= 1'b0;
            if ((pmem_read_o || pmem_write_o) && !pmem_resp_i) begin
                if (!mem_busy) begin
                    mem_busy = 1'b1;
                    mem_wait = 0;
                    for (int i = 0; i < 3; i++) begin
                        mem_wait = mem_wait * 2 + int'(lfsr_q[0]);
                        lfsr_q = lfsr_step(lfsr_q);
                    end
                end else if (mem_wait > 0) begin
                    mem_wait = mem_wait - 1;
                end else begin
                    mem_busy = 1'b0;
                    pmem_resp_i <= 1'b1;
                    if (pmem_write_o) begin
                        mem_store[pmem_address_o] = pmem_wdata_o;
                    end
                    pmem_rdata_i <= mem_store.exists(pmem_address_o) ?
                                    mem_store[pmem_address_o] : fill_line(pmem_address_o);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run hung: no cache response within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        rst_n_i = 1'b0;
        mem_read_i = 1'b0;
        mem_write_i = 1'b0;
        mem_addr_i = '0;
        mem_byte_enable_i = '0;
        mem_wdata_i = '0;
        pmem_rdata_i = '0;
        expect_hit = 1'b0;
        expect_wb = 1'b0;
        lfsr_q = 32'hbb2d_fafb;
        cycle_count = 0;
        cycle_limit = 0;
        load_operations();
        if (op_q.size() == 0) begin
            $display("no operations were loaded from the data file");
            $display("=== FAIL ===");
        end else begin
            cycle_limit = op_q.size() * 40;
            apply_reset();
            @(posedge clk);
            run_operations();
            mem_read_i <= 1'b0;
            mem_write_i <= 1'b0;
            repeat (2) @(posedge clk);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0 && check_count > 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
        end
        $finish;
    end

endmodule : tb_cache

`default_nettype wire

/* cache_checker.sv */
/* Cache checker: shadow of memory as the processor sees it,
   compares read data, hit flags, latency and write-backs */
`timescale 1ns/100ps
`default_nettype none

module cache_checker import cache_pkg::*; (
    input wire logic clk,
    input wire logic rst_n_i,
    input wire logic mem_read_i,
    input wire logic mem_write_i,
    input wire logic [31:0] mem_addr_i,
    input wire logic [MASK_BITS-1:0] mem_byte_enable_i,
    input wire logic [LINE_BITS-1:0] mem_wdata_i,
    input wire logic [LINE_BITS-1:0] rdata_i,
    input wire logic resp_i,
    input wire logic pmem_read_i,
    input wire logic pmem_write_i,
    input wire logic [31:0] pmem_address_i,
    input wire logic [LINE_BITS-1:0] pmem_wdata_i,
    input wire logic expect_hit_i,
    input wire logic expect_wb_i,
    output int error_count_o,
    output int check_count_o
);
    logic [LINE_BITS-1:0] shadow [logic [31:0]];
    logic in_req;
    logic read_prev;
    logic write_prev;
    int cycles;
    int rd_count;
    int wb_count;

    function automatic logic [LINE_BITS-1:0] fill_line(input logic [31:0] addr);
        logic [LINE_BITS-1:0] line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = {addr[31:5], 3'(w), 2'b00} ^ 32'h3c96_a55a;
        end
        return line;
    endfunction

    function automatic logic [LINE_BITS-1:0] shadow_line(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:5], 5'b0};
        return shadow.exists(base) ? shadow[base] : fill_line(base);
    endfunction

    task automatic report(input string msg);
        error_count_o = error_count_o + 1;
        $display("[ERROR] %0t: %s (addr %h)", $time, msg, mem_addr_i);
    endtask

    task automatic finish_request();
        logic [LINE_BITS-1:0] line;
        logic hit;
        hit = (rd_count == 0);
        check_count_o = check_count_o + 1;
        if (hit != expect_hit_i) report($sformatf("hit %0d, expected %0d", hit, expect_hit_i));
        if (!hit && rd_count != 1) report($sformatf("%0d refill reads on a miss", rd_count));
        if (wb_count != int'(expect_wb_i)) report($sformatf("%0d write-backs seen", wb_count));
        if (hit && cycles != 2) report($sformatf("hit answered after %0d cycles", cycles));
        line = shadow_line(mem_addr_i);
        if (mem_read_i && rdata_i !== line) begin
            report($sformatf("read data %h, expected %h", rdata_i, line));
        end
        if (mem_write_i) begin
            for (int b = 0; b < MASK_BITS; b++) begin
                if (mem_byte_enable_i[b]) line[8*b +: 8] = mem_wdata_i[8*b +: 8];
            end
            shadow[{mem_addr_i[31:5], 5'b0}] = line;
        end
        in_req = 1'b0;
    endtask

    initial begin
        error_count_o = 0;
        check_count_o = 0;
    end

    // sampled on the falling edge where every DUT output is settled
    always @(negedge clk) begin
        if (!rst_n_i) begin
            in_req = 1'b0;
            read_prev = 1'b0;
            write_prev = 1'b0;
        end else begin
            if (in_req) begin
                cycles = cycles + 1;
                if (pmem_write_i && !write_prev) begin
                    wb_count = wb_count + 1;
                    if (rd_count != 0) report("write-back after the refill read");
                    if (pmem_address_i[4:0] != 5'b0 || pmem_address_i[7:5] != mem_addr_i[7:5])
                        report($sformatf("write-back address %h", pmem_address_i));
                    if (pmem_wdata_i !== shadow_line(pmem_address_i))
                        report($sformatf("write-back data %h", pmem_wdata_i));
                end
                if (pmem_read_i && !read_prev) begin
                    rd_count = rd_count + 1;
                    if (pmem_address_i != {mem_addr_i[31:5], 5'b0})
                        report($sformatf("refill address %h", pmem_address_i));
                end
                if (resp_i) finish_request();
            end else begin
                // the cache is idle here, also right after reset
                if (resp_i || pmem_read_i || pmem_write_i) begin
                    report("response or memory strobe outside a request");
                end
                if (mem_read_i || mem_write_i) begin
                    in_req = 1'b1;
                    cycles = 0;
                    rd_count = 0;
                    wb_count = 0;
                end
            end
            read_prev = pmem_read_i;
            write_prev = pmem_write_i;
        end
    end

endmodule : cache_checker

`default_nettype wire

/* cache_top.sv */
/* Two-way set-associative write-back cache between a processor
   port and a line-wide memory port */
`timescale 1ns/100ps
`default_nettype none

module cache_top import cache_pkg::*; #(
    parameter int S_INDEX = 3
) (
    input wire logic clk,
    input wire logic rst_n_i,
    input wire logic mem_read_i,
    input wire logic mem_write_i,
    input wire logic [31:0] mem_addr_i,
    input wire logic [MASK_BITS-1:0] mem_byte_enable_i,
    input wire logic [LINE_BITS-1:0] mem_wdata_i,
    output logic [LINE_BITS-1:0] mem_rdata_o,
    output logic mem_resp_o,
    output logic pmem_read_o,
    output logic pmem_write_o,
    output logic [31:0] pmem_address_o,
    output logic [LINE_BITS-1:0] pmem_wdata_o,
    input wire logic [LINE_BITS-1:0] pmem_rdata_i,
    input wire logic pmem_resp_i
);
    localparam int TAG_BITS = 32 - OFFSET_BITS - S_INDEX;

    logic hit;
    logic [WAY_BITS-1:0] victim;
    logic victim_dirty;
    logic lru_load;
    logic use_victim;
    logic addr_victim;
    logic [LINE_BITS-1:0] line;

    cache_way_if #(.S_INDEX(S_INDEX)) way_if [NUM_WAYS] ();

    cache_control #(.S_INDEX(S_INDEX)) cache_control_i (
        .clk, .rst_n_i, .ways_io(way_if),
        .mem_read_i, .mem_write_i, .mem_addr_i, .mem_byte_enable_i, .mem_wdata_i,
        .pmem_resp_i, .pmem_rdata_i,
        .hit_i(hit), .victim_i(victim), .victim_dirty_i(victim_dirty),
        .lru_load_o(lru_load), .use_victim_o(use_victim), .addr_victim_o(addr_victim),
        .mem_resp_o, .pmem_read_o, .pmem_write_o
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way #(.S_INDEX(S_INDEX)) cache_way_i (
            .clk, .rst_n_i, .port_io(way_if[w])
        );
    end

    cache_way_select #(.S_INDEX(S_INDEX)) cache_way_select_i (
        .clk, .rst_n_i, .ways_io(way_if),
        .index_i(mem_addr_i[OFFSET_BITS +: S_INDEX]),
        .tag_i(mem_addr_i[31 -: TAG_BITS]),
        .lru_load_i(lru_load), .use_victim_i(use_victim), .addr_victim_i(addr_victim),
        .hit_o(hit), .victim_o(victim), .victim_dirty_o(victim_dirty),
        .line_o(line), .pmem_address_o
    );

    // one registered line feeds both the processor and the write-back path
    assign mem_rdata_o = line;
    assign pmem_wdata_o = line;

endmodule : cache_top

`default_nettype wire

/* cache_control.sv */
/* Cache controller: FSM through compare, write-back and refill,
   driving index, tag, write data and loads of every way */
`timescale 1ns/100ps
`default_nettype none

module cache_control import cache_pkg::*; #(
    parameter int S_INDEX = 3
) (
    input wire logic clk,
    input wire logic rst_n_i,
    cache_way_if.ctrl ways_io [NUM_WAYS],
    input wire logic mem_read_i,
    input wire logic mem_write_i,
    input wire logic [31:0] mem_addr_i,
    input wire logic [MASK_BITS-1:0] mem_byte_enable_i,
    input wire logic [LINE_BITS-1:0] mem_wdata_i,
    input wire logic pmem_resp_i,
    input wire logic [LINE_BITS-1:0] pmem_rdata_i,
    input wire logic hit_i,
    input wire logic [WAY_BITS-1:0] victim_i,
    input wire logic victim_dirty_i,
    output logic lru_load_o,
    output logic use_victim_o,
    output logic addr_victim_o,
    output logic mem_resp_o,
    output logic pmem_read_o,
    output logic pmem_write_o
);
    localparam int TAG_BITS = 32 - OFFSET_BITS - S_INDEX;

    cache_state_e state_q;
    cache_state_e state_d;
    logic resp_q;
    cache_addr_u req_addr;
    logic [S_INDEX-1:0] index;
    logic [TAG_BITS-1:0] req_tag;
    logic write_hit;
    logic refill_done;
    logic [MASK_BITS-1:0] wmask;
    logic [LINE_BITS-1:0] wline;

    assign req_addr.word = mem_addr_i;

    if (S_INDEX == DEF_INDEX_BITS) begin : g_field_decode
        assign index = req_addr.f.index;
        assign req_tag = req_addr.f.tag;
    end else begin : g_slice_decode
        assign index = req_addr.word[OFFSET_BITS +: S_INDEX];
        assign req_tag = req_addr.word[31 -: TAG_BITS];
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            // the response cycle still sees the old request, so skip it
            ST_IDLE: if ((mem_read_i || mem_write_i) && !resp_q) state_d = ST_COMPARE;
            ST_COMPARE: begin
                if (hit_i) state_d = ST_IDLE;
                else if (victim_dirty_i) state_d = ST_WRITE_BACK;
                else state_d = ST_REFILL;
            end
            ST_WRITE_BACK: if (pmem_resp_i) state_d = ST_REFILL;
            ST_REFILL: if (pmem_resp_i) state_d = ST_COMPARE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            resp_q <= 1'b0;
        end else begin
            state_q <= state_d;
            resp_q <= (state_q == ST_COMPARE) && hit_i;
        end
    end

    assign write_hit = (state_q == ST_COMPARE) && hit_i && mem_write_i;
    assign refill_done = (state_q == ST_REFILL) && pmem_resp_i;
    assign wmask = refill_done ? '1 : (write_hit ? mem_byte_enable_i : '0);
    assign wline = (state_q == ST_REFILL) ? pmem_rdata_i : mem_wdata_i;

    // victim_i names the hit way on a hit and the LRU way otherwise
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way_ctrl
        logic target;

        assign target = (victim_i == WAY_BITS'(w));
        assign ways_io[w].index = index;
        assign ways_io[w].req_tag = req_tag;
        assign ways_io[w].wline = wline;
        assign ways_io[w].wmask = target ? wmask : '0;
        assign ways_io[w].tag_load = target && refill_done;
        assign ways_io[w].valid_load = target && refill_done;
        assign ways_io[w].valid_val = 1'b1;
        assign ways_io[w].dirty_load = target && (refill_done || write_hit);
        assign ways_io[w].dirty_val = write_hit;
    end

    assign lru_load_o = (state_q == ST_COMPARE) && hit_i;
    // on a miss the victim line is registered ahead of write-back
    assign use_victim_o = !hit_i;
    assign addr_victim_o = (state_q == ST_WRITE_BACK);
    assign mem_resp_o = resp_q;
    assign pmem_read_o = (state_q == ST_REFILL);
    assign pmem_write_o = (state_q == ST_WRITE_BACK);

endmodule : cache_control

`default_nettype wire

/* cache_way_select.sv */
/* Way selection: LRU bits, hit and victim choice, the
   registered output line and the memory address mux */
`timescale 1ns/100ps
`default_nettype none

module cache_way_select import cache_pkg::*; #(
    parameter int S_INDEX = 3,
    localparam int TAG_BITS = 32 - OFFSET_BITS - S_INDEX
) (
    input wire logic clk,
    input wire logic rst_n_i,
    cache_way_if.sel ways_io [NUM_WAYS],
    input wire logic [S_INDEX-1:0] index_i,
    input wire logic [TAG_BITS-1:0] tag_i,
    input wire logic lru_load_i,
    input wire logic use_victim_i,
    input wire logic addr_victim_i,
    output logic hit_o,
    output logic [WAY_BITS-1:0] victim_o,
    output logic victim_dirty_o,
    output logic [LINE_BITS-1:0] line_o,
    output logic [31:0] pmem_address_o
);
    localparam int NUM_SETS = 2 ** S_INDEX;

    logic [NUM_WAYS-1:0] way_hit;
    logic [NUM_WAYS-1:0] way_valid;
    logic [NUM_WAYS-1:0] way_dirty;
    logic [LINE_BITS-1:0] way_line [NUM_WAYS];
    logic [TAG_BITS-1:0] way_tag [NUM_WAYS];
    logic [WAY_BITS-1:0] hit_way;
    logic [WAY_BITS-1:0] lru_victim;
    logic [WAY_BITS-1:0] line_way;
    // holds the way used last in each set
    logic [NUM_SETS-1:0] lru_q;
    logic [LINE_BITS-1:0] line_q;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_status
        assign way_hit[w] = ways_io[w].hit;
        assign way_valid[w] = ways_io[w].valid;
        assign way_dirty[w] = ways_io[w].dirty;
        assign way_line[w] = ways_io[w].rline;
        assign way_tag[w] = ways_io[w].tag;
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) hit_way = WAY_BITS'(w);
        end
    end

    assign hit_o = |way_hit;
    assign lru_victim = ~lru_q[index_i];
    // on a hit the target of any load is the hit way itself
    assign victim_o = hit_o ? hit_way : lru_victim;
    assign victim_dirty_o = way_valid[victim_o] && way_dirty[victim_o];
    assign line_way = use_victim_i ? victim_o : hit_way;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lru_q <= '0;
        end else if (lru_load_i) begin
            lru_q[index_i] <= hit_way;
        end
    end

    always_ff @(posedge clk) begin
        line_q <= way_line[line_way];
    end

    assign line_o = line_q;
    assign pmem_address_o = addr_victim_i ? {way_tag[victim_o], index_i, OFFSET_BITS'(0)}
                                          : {tag_i, index_i, OFFSET_BITS'(0)};

endmodule : cache_way_select

`default_nettype wire

/* cache_way.sv */
/* One cache way: byte-writable line storage, tag store,
   valid and dirty bits per set, and the tag comparator */
`timescale 1ns/100ps
`default_nettype none

module cache_way import cache_pkg::*; #(
    parameter int S_INDEX = 3
) (
    input wire logic clk,
    input wire logic rst_n_i,
    cache_way_if.way port_io
);
    localparam int TAG_BITS = 32 - OFFSET_BITS - S_INDEX;
    localparam int NUM_SETS = 2 ** S_INDEX;

    logic [LINE_BITS-1:0] data_q [NUM_SETS];
    logic [TAG_BITS-1:0] tag_q [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;

    // each set bit of the mask enables one byte lane of the line
    always_ff @(posedge clk) begin
        for (int b = 0; b < MASK_BITS; b++) begin
            if (port_io.wmask[b]) begin
                data_q[port_io.index][8*b +: 8] <= port_io.wline[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (port_io.tag_load) begin
            tag_q[port_io.index] <= port_io.req_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (port_io.valid_load) begin
                valid_q[port_io.index] <= port_io.valid_val;
            end
            if (port_io.dirty_load) begin
                dirty_q[port_io.index] <= port_io.dirty_val;
            end
        end
    end

    // reads are combinational so the compare cycle sees the indexed set
    always_comb begin
        port_io.rline = data_q[port_io.index];
        port_io.tag = tag_q[port_io.index];
        port_io.valid = valid_q[port_io.index];
        port_io.dirty = dirty_q[port_io.index];
    end

    // stale tags of invalid entries never count as a hit
    assign port_io.hit = port_io.valid && (port_io.tag == port_io.req_tag);

endmodule : cache_way

`default_nettype wire

/* cache_way_if.sv */
/* Per-way link: controller loads and write data in,
   stored line, tag and status bits back out */
`timescale 1ns/100ps
`default_nettype none

interface cache_way_if import cache_pkg::*; #(
    parameter int S_INDEX = 3
) ();
    localparam int TAG_BITS = 32 - OFFSET_BITS - S_INDEX;

    logic [S_INDEX-1:0] index;
    logic [TAG_BITS-1:0] req_tag;
    logic [MASK_BITS-1:0] wmask;
    logic [LINE_BITS-1:0] wline;
    logic tag_load;
    logic valid_load;
    logic valid_val;
    logic dirty_load;
    logic dirty_val;

    logic [LINE_BITS-1:0] rline;
    logic [TAG_BITS-1:0] tag;
    logic valid;
    logic dirty;
    logic hit;

    modport ctrl (output index, req_tag, wmask, wline, tag_load,
                  valid_load, valid_val, dirty_load, dirty_val);
    modport way (input index, req_tag, wmask, wline, tag_load,
                 valid_load, valid_val, dirty_load, dirty_val,
                 output rline, tag, valid, dirty, hit);
    modport sel (input rline, tag, valid, dirty, hit);
endinterface : cache_way_if

`default_nettype wire

/* cache_pkg.sv */
/* Cache package: line geometry, way count, the address view
   and the controller states shared by the two-way cache */
`default_nettype none

package cache_pkg;

    localparam int LINE_BITS = 256;
    localparam int MASK_BITS = LINE_BITS / 8;
    localparam int OFFSET_BITS = 5;

    // a single LRU bit per set only covers two ways
    localparam int NUM_WAYS = 2;
    localparam int WAY_BITS = 1;

    // index width the field view of the address is laid out for
    localparam int DEF_INDEX_BITS = 3;
    localparam int DEF_TAG_BITS = 32 - OFFSET_BITS - DEF_INDEX_BITS;

    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [DEF_TAG_BITS-1:0] tag;
            logic [DEF_INDEX_BITS-1:0] index;
            logic [OFFSET_BITS-1:0] offset;
        } f;
    } cache_addr_u;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITE_BACK,
        ST_REFILL
    } cache_state_e;

endpackage : cache_pkg

`default_nettype wire
